// File: rtl/cp15_pkg.sv
`default_nettype none

package cp15_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic types.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word;
	typedef logic [3:0] reg_num;

	typedef struct packed {
		reg_num crn;
		logic   load; // High for a read.
	} coproc_decode;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register layouts.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic [21:0] reserved;
		logic        v;        // Vectors high.
		logic        r;
		logic        s;
		logic [2:0]  sbo;      // Always one.
		logic        w;        // Write buffer.
		logic        c;        // Data cache.
		logic        a;        // Alignment check.
		logic        m;        // MMU enable.
	} syscfg_t;

	typedef struct packed {
		logic [17:0] base;
		logic [13:0] reserved;
	} ttbr_t;

	typedef logic [15:0][1:0] domain_t; // One access field per domain.

	typedef struct packed {
		logic [23:0] reserved;
		logic [3:0]  domain;
		logic [3:0]  status;
	} fsr_t;

	// Abort report from the memory side.
	typedef struct packed {
		word        addr;
		logic [3:0] domain;
		logic [3:0] status;
	} fault_t;

	typedef struct packed {
		logic        mmu_en;
		logic        align_chk;
		logic        dcache_en;
		logic        vectors_high;
		logic [17:0] tt_base;
		domain_t     domains;
	} mmu_cfg_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// CRn map and constants.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam reg_num CRN_CPUID  = 4'd0;
	localparam reg_num CRN_SYSCFG = 4'd1;
	localparam reg_num CRN_TTBR   = 4'd2;
	localparam reg_num CRN_DOMAIN = 4'd3;
	localparam reg_num CRN_FSR    = 4'd5;
	localparam reg_num CRN_FAR    = 4'd6;

	localparam word CPUID_VALUE  = 32'h5a01_0b17;
	localparam word SYSCFG_RESET = 32'h0000_0070; // Only the sbo bits.
	localparam word TTBR_MASK    = 32'hffff_c000;

	localparam int PADDR_W = 6;

endpackage

`default_nettype wire

// File: rtl/cp15_apb_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module cp15_apb_bridge (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [cp15_pkg::PADDR_W-1:0]  paddr,
	input  cp15_pkg::word                 pwdata,
	output logic                          pready,
	output cp15_pkg::word                 prdata,
	output logic                          pslverr,

	output logic                          transfer,
	output cp15_pkg::coproc_decode        dec,
	output cp15_pkg::word                 write,
	input  cp15_pkg::word                 read,
	input  logic                          hit
);

	logic access;
	logic setup_seen;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Phase tracking.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign access = psel && penable;

	// Set for the cycle after a setup phase.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			setup_seen <= 1'b0;
		end else begin
			setup_seen <= psel && !penable;
		end
	end

	// One pulse per access, only after a proper setup.
	assign transfer = access && setup_seen;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request and response.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign dec.crn  = paddr[5:2]; // Byte offset bits ignored.
	assign dec.load = !pwrite;
	assign write    = pwdata;

	assign pready = 1'b1; // No wait states.

	assign prdata  = (access && hit) ? read : '0;
	assign pslverr = access && !hit; // Unmapped CRn.

endmodule

`default_nettype wire

// File: rtl/core_cp15_syscfg.sv
`timescale 1ns/10ps
`default_nettype none

module core_cp15_syscfg (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   transfer,
	input  cp15_pkg::coproc_decode dec,
	input  cp15_pkg::word          write,
	output cp15_pkg::word          read,
	output cp15_pkg::syscfg_t      cfg
);

	cp15_pkg::syscfg_t cfg_q;
	cp15_pkg::syscfg_t wr;
	cp15_pkg::syscfg_t next;

	assign wr = cp15_pkg::syscfg_t'(write);

	// Start from reset so sbo stays one and reserved stays zero.
	always_comb begin
		next   = cp15_pkg::syscfg_t'(cp15_pkg::SYSCFG_RESET);
		next.m = wr.m;
		next.a = wr.a;
		next.c = wr.c;
		next.w = wr.w;
		next.s = wr.s;
		next.r = wr.r;
		next.v = wr.v;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_q <= cp15_pkg::syscfg_t'(cp15_pkg::SYSCFG_RESET);
		end else if (transfer && !dec.load) begin
			cfg_q <= next;
		end
	end

	assign read = cp15_pkg::word'(cfg_q);
	assign cfg  = cfg_q;

endmodule

`default_nettype wire

// File: rtl/core_cp15_reg.sv
`timescale 1ns/10ps
`default_nettype none

module core_cp15_reg #(
	parameter type payload_t = cp15_pkg::word
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   transfer,
	input  cp15_pkg::coproc_decode dec,
	input  cp15_pkg::word          write,
	output cp15_pkg::word          read,
	output payload_t               value
);

	// Bits kept on a write, picked by layout.
	localparam cp15_pkg::word KEEP =
		(type(payload_t) == type(cp15_pkg::ttbr_t)) ? cp15_pkg::TTBR_MASK : '1;

	payload_t value_q;

	function automatic payload_t masked(input cp15_pkg::word data);
		return payload_t'(data & KEEP);
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			value_q <= '0;
		end else if (transfer && !dec.load) begin
			value_q <= masked(write);
		end
	end

	assign read  = cp15_pkg::word'(value_q);
	assign value = value_q;

endmodule

`default_nettype wire

// File: rtl/core_cp15_fault.sv
`timescale 1ns/10ps
`default_nettype none

module core_cp15_fault (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   transfer_far,
	input  logic                   transfer_fsr,
	input  cp15_pkg::coproc_decode dec,
	input  cp15_pkg::word          write,

	input  logic                   fault_valid,
	input  cp15_pkg::fault_t       fault,

	output cp15_pkg::word          read_far,
	output cp15_pkg::word          read_fsr
);

	cp15_pkg::word  far_q;
	cp15_pkg::fsr_t fsr_q;
	cp15_pkg::fsr_t write_fsr;

	assign write_fsr = cp15_pkg::fsr_t'(write);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Abort capture beats software writes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			far_q <= '0;
		end else if (fault_valid) begin
			far_q <= fault.addr;
		end else if (transfer_far && !dec.load) begin
			far_q <= write;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fsr_q <= '0;
		end else if (fault_valid) begin
			fsr_q.reserved <= '0;
			fsr_q.domain   <= fault.domain;
			fsr_q.status   <= fault.status;
		end else if (transfer_fsr && !dec.load) begin
			fsr_q.reserved <= '0; // Reads back zero.
			fsr_q.domain   <= write_fsr.domain;
			fsr_q.status   <= write_fsr.status;
		end
	end

	assign read_far = far_q;
	assign read_fsr = cp15_pkg::word'(fsr_q);

endmodule

`default_nettype wire

// File: rtl/core_cp15.sv
`timescale 1ns/10ps
`default_nettype none

module core_cp15 (
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   transfer,
	input  cp15_pkg::coproc_decode dec,
	input  cp15_pkg::word          write,
	output cp15_pkg::word          read,
	output logic                   hit,

	input  logic                   fault_valid,
	input  cp15_pkg::fault_t       fault,

	output cp15_pkg::mmu_cfg_t     mmu_cfg
);

	cp15_pkg::reg_num crn;

	cp15_pkg::word read_syscfg;
	cp15_pkg::word read_ttbr;
	cp15_pkg::word read_domain;
	cp15_pkg::word read_far;
	cp15_pkg::word read_fsr;

	cp15_pkg::syscfg_t cfg;
	cp15_pkg::ttbr_t   ttbr;
	cp15_pkg::domain_t domain;

	assign crn = dec.crn;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Register blocks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	core_cp15_syscfg u_syscfg (
		.clk      (clk),
		.rst_n    (rst_n),
		.transfer (transfer && crn == cp15_pkg::CRN_SYSCFG),
		.dec      (dec),
		.write    (write),
		.read     (read_syscfg),
		.cfg      (cfg)
	);

	core_cp15_reg #(.payload_t(cp15_pkg::ttbr_t)) u_ttbr (
		.clk      (clk),
		.rst_n    (rst_n),
		.transfer (transfer && crn == cp15_pkg::CRN_TTBR),
		.dec      (dec),
		.write    (write),
		.read     (read_ttbr),
		.value    (ttbr)
	);

	core_cp15_reg #(.payload_t(cp15_pkg::domain_t)) u_domain (
		.clk      (clk),
		.rst_n    (rst_n),
		.transfer (transfer && crn == cp15_pkg::CRN_DOMAIN),
		.dec      (dec),
		.write    (write),
		.read     (read_domain),
		.value    (domain)
	);

	core_cp15_fault u_fault (
		.clk          (clk),
		.rst_n        (rst_n),
		.transfer_far (transfer && crn == cp15_pkg::CRN_FAR),
		.transfer_fsr (transfer && crn == cp15_pkg::CRN_FSR),
		.dec          (dec),
		.write        (write),
		.fault_valid  (fault_valid),
		.fault        (fault),
		.read_far     (read_far),
		.read_fsr     (read_fsr)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read select.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		hit = 1'b1;
		unique case (crn)
			cp15_pkg::CRN_CPUID:  read = cp15_pkg::CPUID_VALUE; // Writes fall on the floor.
			cp15_pkg::CRN_SYSCFG: read = read_syscfg;
			cp15_pkg::CRN_TTBR:   read = read_ttbr;
			cp15_pkg::CRN_DOMAIN: read = read_domain;
			cp15_pkg::CRN_FSR:    read = read_fsr;
			cp15_pkg::CRN_FAR:    read = read_far;
			default: begin
				read = '0;
				hit  = 1'b0;
			end
		endcase
	end

	// Live MMU view.
	assign mmu_cfg.mmu_en       = cfg.m;
	assign mmu_cfg.align_chk    = cfg.a;
	assign mmu_cfg.dcache_en    = cfg.c;
	assign mmu_cfg.vectors_high = cfg.v;
	assign mmu_cfg.tt_base      = ttbr.base;
	assign mmu_cfg.domains      = domain;

endmodule

`default_nettype wire

// File: rtl/cp15_top.sv
`timescale 1ns/10ps
`default_nettype none

module cp15_top (
	input  logic                          clk,
	input  logic                          rst_n,

	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [cp15_pkg::PADDR_W-1:0]  paddr,
	input  cp15_pkg::word                 pwdata,
	output logic                          pready,
	output cp15_pkg::word                 prdata,
	output logic                          pslverr,

	input  logic                          fault_valid,
	input  cp15_pkg::fault_t              fault,

	output cp15_pkg::mmu_cfg_t            mmu_cfg
);

	logic                   transfer;
	logic                   hit;
	cp15_pkg::coproc_decode dec;
	cp15_pkg::word          write;
	cp15_pkg::word          read;

	cp15_apb_bridge u_bridge (
		.clk      (clk),
		.rst_n    (rst_n),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pready   (pready),
		.prdata   (prdata),
		.pslverr  (pslverr),
		.transfer (transfer),
		.dec      (dec),
		.write    (write),
		.read     (read),
		.hit      (hit)
	);

	core_cp15 u_cp15 (
		.clk         (clk),
		.rst_n       (rst_n),
		.transfer    (transfer),
		.dec         (dec),
		.write       (write),
		.read        (read),
		.hit         (hit),
		.fault_valid (fault_valid),
		.fault       (fault),
		.mmu_cfg     (mmu_cfg)
	);

endmodule

`default_nettype wire

// File: bench/cp15_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cp15_properties (
	input logic          clk,
	input logic          rst_n,
	input logic          psel,
	input logic          penable,
	input logic          pready,
	input logic          pslverr,
	input logic          transfer,
	input cp15_pkg::word prdata
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB response rules.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable) |-> pready)
		else $error("pready low during an access phase");

	slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else $error("pslverr high outside an access phase");

	// Coprocessor side.
	transfer_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		transfer |-> (psel && penable))
		else $error("transfer pulse outside an access phase");

	idle_rdata_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!psel |-> (prdata == '0))
		else $error("prdata not zero while psel is low");

endmodule

bind cp15_apb_bridge cp15_properties u_properties (
	.clk      (clk),
	.rst_n    (rst_n),
	.psel     (psel),
	.penable  (penable),
	.pready   (pready),
	.pslverr  (pslverr),
	.transfer (transfer),
	.prdata   (prdata)
);

`default_nettype wire

// File: bench/cp15_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cp15_tb;

	// One parsed stimulus line.
	typedef struct packed {
		logic [7:0]       op;
		cp15_pkg::reg_num crn;
		cp15_pkg::word    data;
		cp15_pkg::word    exp_val;
		logic             err;
		logic [3:0]       ext1;
		logic [3:0]       ext2;
	} stim_line_t;

	logic                         clk;
	logic                         rst_n;
	logic                         psel;
	logic                         penable;
	logic                         pwrite;
	logic [cp15_pkg::PADDR_W-1:0] paddr;
	cp15_pkg::word                pwdata;
	logic                         pready;
	cp15_pkg::word                prdata;
	logic                         pslverr;
	logic                         fault_valid;
	cp15_pkg::fault_t             fault;
	cp15_pkg::mmu_cfg_t           mmu_cfg;

	stim_line_t lines[$];
	string      names[$];
	logic       loaded;
	logic       file_ok;
	int         value_errors;
	int         other_errors;

	cp15_top u_cp15_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.pready      (pready),
		.prdata      (prdata),
		.pslverr     (pslverr),
		.fault_valid (fault_valid),
		.fault       (fault),
		.mmu_cfg     (mmu_cfg)
	);

	always #10 clk = ~clk;

	// Budget of ten cycles per line plus margin.
	initial begin
		wait (loaded === 1'b1);
		repeat (lines.size() * 10 + 100) @(posedge clk);
		$display("Watchdog expired before the stimulus finished.");
		$display("ERRORS FOUND");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus file.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic load_stimulus(output logic ok);
		int          fd;
		int          n;
		string       line;
		string       name;
		string       op_s;
		logic [31:0] crn_v;
		logic [31:0] data_v;
		logic [31:0] exp_v;
		logic [31:0] err_v;
		logic [31:0] ext1_v;
		logic [31:0] ext2_v;
		stim_line_t  s;
		ok = 1'b0;
		fd = $fopen("bench/cp15_stim.txt", "r");
		if (fd == 0) begin
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue; // Blank or column notes.
			end
			n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op_s,
				crn_v, data_v, exp_v, err_v, ext1_v, ext2_v);
			if (n != 8) begin
				$display("Stimulus line could not be parsed: %0s", line);
				other_errors++;
				continue;
			end
			s.op      = op_s.getc(0);
			s.crn     = crn_v[3:0];
			s.data    = data_v;
			s.exp_val = exp_v;
			s.err     = err_v[0];
			s.ext1    = ext1_v[3:0];
			s.ext2    = ext2_v[3:0];
			lines.push_back(s);
			names.push_back(name);
		end
		$fclose(fd);
		ok = 1'b1;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// APB and abort drivers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string name, input cp15_pkg::word exp,
		input cp15_pkg::word act);
		assert (act === exp) else begin
			$display("Fail %0s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic apb_access(input logic wr, input cp15_pkg::reg_num crn,
		input cp15_pkg::word data, input logic with_abort,
		input cp15_pkg::fault_t abort_rpt, output cp15_pkg::word rdata,
		output logic err);
		int waits;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = {crn, 2'b00};
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		if (with_abort) begin
			fault_valid = 1'b1; // Lands on the same edge as the write.
			fault       = abort_rpt;
		end
		#5;
		waits = 0;
		while (!pready && waits < 8) begin
			@(negedge clk);
			#5;
			waits++;
		end
		assert (pready) else begin
			$display("Slave never raised pready during the access phase.");
			other_errors++;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel        = 1'b0;
		penable     = 1'b0;
		fault_valid = 1'b0;
	endtask

	task automatic abort_only(input cp15_pkg::fault_t abort_rpt);
		@(negedge clk);
		fault_valid = 1'b1;
		fault       = abort_rpt;
		@(negedge clk);
		fault_valid = 1'b0;
	endtask

	task automatic run_line(input string name, input stim_line_t s);
		cp15_pkg::word    rdata;
		logic             err;
		cp15_pkg::fault_t rpt;
		cp15_pkg::word    far_exp;
		rpt = '0;
		case (s.op)
			"W": begin
				apb_access(1'b1, s.crn, s.data, 1'b0, rpt, rdata, err);
				check_value(name, {31'b0, s.err}, {31'b0, err});
			end
			"R": begin
				apb_access(1'b0, s.crn, '0, 1'b0, rpt, rdata, err);
				check_value(name, s.exp_val, rdata);
				check_value({name, "_err"}, {31'b0, s.err}, {31'b0, err});
			end
			"F": begin
				far_exp    = $urandom; // Abort address always wins.
				rpt.addr   = far_exp;
				rpt.domain = s.ext1;
				rpt.status = s.ext2;
				if (s.crn != 4'd0) begin
					apb_access(1'b1, s.crn, s.data, 1'b1, rpt, rdata, err);
					check_value({name, "_err"}, {31'b0, s.err}, {31'b0, err});
				end else begin
					abort_only(rpt);
				end
				apb_access(1'b0, cp15_pkg::CRN_FAR, '0, 1'b0, rpt, rdata, err);
				check_value({name, "_far"}, far_exp, rdata);
				apb_access(1'b0, cp15_pkg::CRN_FSR, '0, 1'b0, rpt, rdata, err);
				check_value({name, "_fsr"}, s.exp_val, rdata);
			end
			"M": begin
				@(negedge clk);
				#5;
				check_value({name, "_ctl"}, {28'b0, s.ext1},
					{28'b0, mmu_cfg.mmu_en, mmu_cfg.align_chk,
					mmu_cfg.dcache_en, mmu_cfg.vectors_high});
				check_value({name, "_base"}, s.exp_val, {14'b0, mmu_cfg.tt_base});
				check_value({name, "_dom"}, s.data, mmu_cfg.domains);
			end
			default: begin
				$display("Stimulus line %0s has an unknown operation %c.", name, s.op);
				other_errors++;
			end
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		fault_valid  = 1'b0;
		fault        = '0;
		value_errors = 0;
		other_errors = 0;
		loaded       = 1'b0;
		void'($urandom(32'h79e7_f5c9));
		load_stimulus(file_ok);
		if (!file_ok) begin
			$display("Stimulus file bench/cp15_stim.txt could not be opened.");
			$display("ERRORS FOUND");
			$finish;
		end else begin
			loaded = 1'b1;
			repeat (8) @(negedge clk);
			rst_n = 1'b1;
			foreach (lines[i]) begin
				run_line(names[i], lines[i]);
			end
			repeat (2) @(negedge clk);
			$display("Closing report: %0d value errors, %0d other errors over %0d lines",
				value_errors, other_errors, lines.size());
			if (value_errors == 0 && other_errors == 0) begin
				$display("NO ERRORS");
			end else begin
				$display("ERRORS FOUND");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: bench/cp15_stim.txt
# name op crn data expect err ext1 ext2, numbers in hex. R checks prdata, W only pslverr.
# F aborts with ext1 domain, ext2 status, expect is FSR, crn 5 or 6 writes data alongside.
# M checks mmu_cfg: data domains, expect tt_base, ext1 the m a c v bits.
rst_sys     R 1 00000000 00000070 0 0 0
rst_ttbr    R 2 00000000 00000000 0 0 0
rst_dom     R 3 00000000 00000000 0 0 0
rst_fsr     R 5 00000000 00000000 0 0 0
rst_far     R 6 00000000 00000000 0 0 0
rst_mmu     M 0 00000000 00000000 0 0 0
cpuid_rd    R 0 00000000 5a010b17 0 0 0
cpuid_wr    W 0 12345678 00000000 0 0 0
cpuid_chk   R 0 00000000 5a010b17 0 0 0
sys_wr_all  W 1 ffffffff 00000000 0 0 0
sys_rd_all  R 1 00000000 000003ff 0 0 0
mmu_all_on  M 0 00000000 00000000 0 f 0
sys_wr      W 1 00000205 00000000 0 0 0
sys_rd      R 1 00000000 00000275 0 0 0
ttbr_wr     W 2 12345678 00000000 0 0 0
ttbr_rd     R 2 00000000 12344000 0 0 0
dom_wr      W 3 a5c30ff1 00000000 0 0 0
dom_rd      R 3 00000000 a5c30ff1 0 0 0
mmu_set     M 0 a5c30ff1 000048d1 0 b 0
bad4_wr     W 4 deadbeef 00000000 1 0 0
bad4_rd     R 4 00000000 00000000 1 0 0
bad7_rd     R 7 00000000 00000000 1 0 0
bad9_wr     W 9 ffffffff 00000000 1 0 0
bada_rd     R a 00000000 00000000 1 0 0
badf_wr     W f 00000000 00000000 1 0 0
badf_rd     R f 00000000 00000000 1 0 0
keep_sys    R 1 00000000 00000275 0 0 0
keep_ttbr   R 2 00000000 12344000 0 0 0
keep_dom    R 3 00000000 a5c30ff1 0 0 0
fsr_wr      W 5 ffffffff 00000000 0 0 0
fsr_rd      R 5 00000000 000000ff 0 0 0
far_wr      W 6 c0ffee00 00000000 0 0 0
far_rd      R 6 00000000 c0ffee00 0 0 0
abort_solo  F 0 00000000 0000003c 0 3 c
abort_far   F 6 11223344 00000095 0 9 5
abort_fsr   F 5 000000ff 00000027 0 2 7
mmu_after   M 0 a5c30ff1 000048d1 0 b 0
cpuid_end   R 0 00000000 5a010b17 0 0 0

// File: all.f
rtl/cp15_pkg.sv
rtl/cp15_apb_bridge.sv
rtl/core_cp15_syscfg.sv
rtl/core_cp15_reg.sv
rtl/core_cp15_fault.sv
rtl/core_cp15.sv
rtl/cp15_top.sv
bench/cp15_properties.sv
bench/cp15_tb.sv

// File: Makefile
SRC := $(shell grep -v '^+' all.f)

.PHONY: run clean

run: obj_dir/Vcp15_tb
	@out="$$(./obj_dir/Vcp15_tb)"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

obj_dir/Vcp15_tb: all.f $(SRC)
	verilator --binary --assert --top-module cp15_tb -f all.f -o Vcp15_tb

clean:
	rm -rf obj_dir
